// File: files.f
+incdir+include
hw/exec_pkg.sv
hw/exec_ifs.sv
hw/instr_decoder.sv
hw/int_alu.sv
hw/iter_multiplier.sv
hw/csr_unit.sv
hw/execute_stage.sv
hw/exec_top.sv
tb/exec_asserts.sv
tb/exec_tb.sv

// File: hw/csr_unit.sv
module csr_unit import exec_pkg::*; (
  input logic clk,
  input logic rst,
  csr_if.unit c
);

  localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
  localparam csr_addr_t ADDR_MEPC = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE = 12'h342;
  localparam csr_addr_t ADDR_MTVAL = 12'h343;

  word_t mscratch;
  word_t mepc;
  word_t mcause;
  word_t mtval;

  always_comb begin
    case (c.raddr)
      ADDR_MSCRATCH: c.rdata = mscratch;
      ADDR_MEPC: c.rdata = mepc;
      ADDR_MCAUSE: c.rdata = mcause;
      ADDR_MTVAL: c.rdata = mtval;
      default: c.rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mscratch <= '0;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
    end else if (c.exc) begin
      // a trap takes priority over any write from the same instruction.
      mepc <= c.epc;
      mcause <= word_t'(c.ecause);
      mtval <= c.etval;
    end else if (c.wren) begin
      case (c.waddr)
        ADDR_MSCRATCH: mscratch <= c.wdata;
        ADDR_MEPC: mepc <= c.wdata;
        ADDR_MCAUSE: mcause <= c.wdata;
        ADDR_MTVAL: mtval <= c.wdata;
        default: mscratch <= mscratch;
      endcase
    end
  end

endmodule

// File: hw/exec_ifs.sv
interface mul_if import exec_pkg::*; ();
  word_t rdata1;
  word_t rdata2;
  mul_op_e op;
  logic enable;
  word_t result;
  logic ready;

  modport stage (output rdata1, rdata2, op, enable, input result, ready);
  modport unit (input rdata1, rdata2, op, enable, output result, ready);
endinterface

interface csr_if import exec_pkg::*; ();
  csr_addr_t raddr;
  word_t rdata;
  logic wren;
  csr_addr_t waddr;
  word_t wdata;
  // exception capture, pulsed once at retirement.
  logic exc;
  word_t epc;
  ecause_t ecause;
  word_t etval;

  modport stage (
    output raddr, wren, waddr, wdata, exc, epc, ecause, etval,
    input rdata
  );
  modport unit (
    input raddr, wren, waddr, wdata, exc, epc, ecause, etval,
    output rdata
  );
endinterface

// File: hw/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0] ecause_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // encoded as funct3[1:0] of the M extension.
  typedef enum logic [1:0] {MOP_MUL, MOP_MULH, MOP_MULHSU, MOP_MULHU} mul_op_e;

  typedef enum logic [1:0] {CSR_RW, CSR_RS, CSR_RC} csr_op_e;

  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;

  localparam ecause_t CAUSE_ILLEGAL = 4'd2;
  localparam ecause_t CAUSE_BREAKPOINT = 4'd3;
  localparam ecause_t CAUSE_ECALL_M = 4'd11;

  typedef struct packed {
    word_t imm;
    logic use_imm;
    logic rd_wr;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic is_mul;
    logic is_csr;
    alu_op_e alu_op;
    mul_op_e mul_op;
    csr_op_e csr_op;
    logic ecall;
    logic ebreak;
    logic illegal;
  } ctrl_t;

endpackage

// File: hw/exec_top.sv
module exec_top import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input word_t in_instr,
  input word_t in_pc,
  input word_t in_rdata1,
  input word_t in_rdata2,
  input logic clear,
  output logic stall,
  output logic wb_wren,
  output reg_addr_t wb_waddr,
  output word_t wb_wdata,
  output logic exc_valid,
  output ecause_t exc_cause
);

  ctrl_t ctrl;
  word_t alu_res;

  mul_if mul_bus ();
  csr_if csr_bus ();

  instr_decoder decoder_inst (
    .instr (in_instr),
    .ctrl (ctrl)
  );

  int_alu alu_inst (
    .rdata1 (in_rdata1),
    .rdata2 (in_rdata2),
    .imm (ctrl.imm),
    .use_imm (ctrl.use_imm),
    .op (ctrl.alu_op),
    .res (alu_res)
  );

  iter_multiplier multiplier_inst (
    .clk (clk),
    .rst (rst),
    .m (mul_bus.unit)
  );

  csr_unit csr_inst (
    .clk (clk),
    .rst (rst),
    .c (csr_bus.unit)
  );

  execute_stage stage_inst (
    .clk (clk),
    .rst (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_pc (in_pc),
    .in_rdata1 (in_rdata1),
    .in_rdata2 (in_rdata2),
    .ctrl (ctrl),
    .alu_res (alu_res),
    .clear (clear),
    .m (mul_bus.stage),
    .c (csr_bus.stage),
    .stall (stall),
    .wb_wren (wb_wren),
    .wb_waddr (wb_waddr),
    .wb_wdata (wb_wdata),
    .exc_valid (exc_valid),
    .exc_cause (exc_cause)
  );

endmodule

// File: hw/execute_stage.sv
module execute_stage import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input word_t in_instr,
  input word_t in_pc,
  input word_t in_rdata1,
  input word_t in_rdata2,
  input ctrl_t ctrl,
  input word_t alu_res,
  input logic clear,
  mul_if.stage m,
  csr_if.stage c,
  output logic stall,
  output logic wb_wren,
  output reg_addr_t wb_waddr,
  output word_t wb_wdata,
  output logic exc_valid,
  output ecause_t exc_cause
);

  reg_addr_t rd;
  reg_addr_t rs1;
  word_t npc;
  word_t result;
  logic accept;
  logic exc;
  ecause_t cause;

  logic mul_busy;
  logic mul_start;
  logic mul_done;
  reg_addr_t mul_rd;
  word_t mul_a;
  word_t mul_b;
  mul_op_e mul_op_q;

  assign rd = in_instr[11:7];
  assign rs1 = in_instr[19:15];
  assign npc = in_pc + word_t'(4);

  assign stall = mul_busy;
  assign accept = in_valid && !mul_busy && !clear;

  // a ready left over from a killed multiply can line up with the new enable.
  assign mul_done = mul_busy && !mul_start && m.ready;

  always_comb begin
    exc = 1'b1;
    cause = CAUSE_ILLEGAL;
    if (ctrl.illegal) begin
      cause = CAUSE_ILLEGAL;
    end else if (ctrl.ebreak) begin
      cause = CAUSE_BREAKPOINT;
    end else if (ctrl.ecall) begin
      cause = CAUSE_ECALL_M;
    end else begin
      exc = 1'b0;
    end
  end

  always_comb begin
    if (ctrl.lui) begin
      result = ctrl.imm;
    end else if (ctrl.auipc) begin
      result = in_pc + ctrl.imm;
    end else if (ctrl.jal || ctrl.jalr) begin
      result = npc;
    end else if (ctrl.is_csr) begin
      result = c.rdata;
    end else begin
      result = alu_res;
    end
  end

  always_comb begin
    case (ctrl.csr_op)
      CSR_RS: c.wdata = c.rdata | in_rdata1;
      CSR_RC: c.wdata = c.rdata & ~in_rdata1;
      default: c.wdata = in_rdata1;
    endcase
  end

  // set and clear with rs1 = x0 only read the CSR.
  assign c.raddr = in_instr[31:20];
  assign c.waddr = in_instr[31:20];
  assign c.wren = accept && ctrl.is_csr && !exc && (ctrl.csr_op == CSR_RW || rs1 != '0);
  assign c.exc = accept && exc;
  assign c.epc = in_pc;
  assign c.ecause = cause;
  assign c.etval = in_instr;

  assign m.enable = mul_start;
  assign m.rdata1 = mul_a;
  assign m.rdata2 = mul_b;
  assign m.op = mul_op_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      mul_busy <= 1'b0;
      mul_start <= 1'b0;
      wb_wren <= 1'b0;
      exc_valid <= 1'b0;
    end else begin
      mul_start <= 1'b0;
      wb_wren <= 1'b0;
      exc_valid <= 1'b0;
      if (clear) begin
        mul_busy <= 1'b0;
      end else if (mul_done) begin
        mul_busy <= 1'b0;
        wb_wren <= mul_rd != '0;
      end else if (accept) begin
        exc_valid <= exc;
        if (ctrl.is_mul && !exc) begin
          mul_busy <= 1'b1;
          mul_start <= 1'b1;
        end else begin
          wb_wren <= ctrl.rd_wr && !exc && rd != '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mul_rd <= rd;
      mul_a <= in_rdata1;
      mul_b <= in_rdata2;
      mul_op_q <= ctrl.mul_op;
      exc_cause <= cause;
    end
    if (mul_done) begin
      wb_waddr <= mul_rd;
      wb_wdata <= m.result;
    end else if (accept) begin
      wb_waddr <= rd;
      wb_wdata <= result;
    end
  end

endmodule

// File: hw/instr_decoder.sv
module instr_decoder import exec_pkg::*; (
  input word_t instr,
  output ctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_u;
  word_t imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic alu_op_e f3_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000: return alt ? ALU_SUB : ALU_ADD;
      3'b001: return ALU_SLL;
      3'b010: return ALU_SLT;
      3'b011: return ALU_SLTU;
      3'b100: return ALU_XOR;
      3'b101: return alt ? ALU_SRA : ALU_SRL;
      3'b110: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    case (opcode)
      7'b0110011: begin
        ctrl.rd_wr = 1'b1;
        if (funct7 == 7'b0000001) begin
          // division is not implemented here.
          ctrl.is_mul = 1'b1;
          ctrl.mul_op = mul_op_e'(funct3[1:0]);
          ctrl.illegal = funct3[2];
        end else begin
          ctrl.alu_op = f3_op(funct3, funct7[5]);
          ctrl.illegal = !(funct7 == 7'b0000000 ||
                           (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
        end
      end
      7'b0010011: begin
        ctrl.rd_wr = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm = imm_i;
        ctrl.alu_op = f3_op(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001) begin
          ctrl.illegal = funct7 != 7'b0000000;
        end else if (funct3 == 3'b101) begin
          ctrl.illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
        end
      end
      7'b0110111: begin
        ctrl.rd_wr = 1'b1;
        ctrl.lui = 1'b1;
        ctrl.imm = imm_u;
      end
      7'b0010111: begin
        ctrl.rd_wr = 1'b1;
        ctrl.auipc = 1'b1;
        ctrl.imm = imm_u;
      end
      7'b1101111: begin
        ctrl.rd_wr = 1'b1;
        ctrl.jal = 1'b1;
        ctrl.imm = imm_j;
      end
      7'b1100111: begin
        ctrl.rd_wr = 1'b1;
        ctrl.jalr = 1'b1;
        ctrl.imm = imm_i;
        ctrl.illegal = funct3 != 3'b000;
      end
      7'b1110011: begin
        if (instr == 32'h0000_0073) begin
          ctrl.ecall = 1'b1;
        end else if (instr == 32'h0010_0073) begin
          ctrl.ebreak = 1'b1;
        end else begin
          ctrl.is_csr = 1'b1;
          ctrl.rd_wr = 1'b1;
          case (funct3)
            3'b001: ctrl.csr_op = CSR_RW;
            3'b010: ctrl.csr_op = CSR_RS;
            3'b011: ctrl.csr_op = CSR_RC;
            default: ctrl.illegal = 1'b1;
          endcase
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

// File: hw/int_alu.sv
module int_alu import exec_pkg::*; (
  input word_t rdata1,
  input word_t rdata2,
  input word_t imm,
  input logic use_imm,
  input alu_op_e op,
  output word_t res
);

  word_t opb;
  logic [4:0] shamt;

  assign opb = use_imm ? imm : rdata2;
  assign shamt = opb[4:0];

  always_comb begin
    case (op)
      ALU_ADD: res = rdata1 + opb;
      ALU_SUB: res = rdata1 - opb;
      ALU_SLL: res = rdata1 << shamt;
      ALU_SLT: res = word_t'($signed(rdata1) < $signed(opb));
      ALU_SLTU: res = word_t'(rdata1 < opb);
      ALU_XOR: res = rdata1 ^ opb;
      ALU_SRL: res = rdata1 >> shamt;
      ALU_SRA: res = word_t'($signed(rdata1) >>> shamt);
      ALU_OR: res = rdata1 | opb;
      ALU_AND: res = rdata1 & opb;
      default: res = '0;
    endcase
  end

endmodule

// File: hw/iter_multiplier.sv
`include "exec_config.svh"

module iter_multiplier import exec_pkg::*; (
  input logic clk,
  input logic rst,
  mul_if.unit m
);

  localparam int CW = $clog2(`MUL_STEPS + 1);

  mul_state_e state;
  logic [CW-1:0] cnt;
  logic [2*`XLEN-1:0] acc;
  word_t mcand;
  word_t mplier;
  word_t corr;
  mul_op_e op_q;
  logic a_signed;
  logic b_signed;

  assign a_signed = (m.op == MOP_MULH) || (m.op == MOP_MULHSU);
  assign b_signed = (m.op == MOP_MULH);

  // the unsigned product is too large in the high word by this amount
  // for each operand that is negative as a signed value.
  assign corr = ((a_signed && m.rdata1[`XLEN-1]) ? m.rdata2 : '0) +
                ((b_signed && m.rdata2[`XLEN-1]) ? m.rdata1 : '0);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= MUL_IDLE;
    end else if (m.enable) begin
      state <= MUL_RUN;
    end else if (state == MUL_RUN && cnt == CW'(`MUL_STEPS - 1)) begin
      state <= MUL_DONE;
    end else if (state == MUL_DONE) begin
      state <= MUL_IDLE;
    end
  end

  // msb-first shift-add. the negated correction sits in the low word and
  // reaches the high word after all shifts. the load edge already covers
  // the correction and the top bit, so the count starts at two.
  always_ff @(posedge clk) begin
    if (m.enable) begin
      op_q <= m.op;
      mcand <= m.rdata1;
      mplier <= m.rdata2 << 1;
      acc <= ({{`XLEN{1'b0}}, -corr} << 1) +
             (m.rdata2[`XLEN-1] ? {{`XLEN{1'b0}}, m.rdata1} : '0);
      cnt <= CW'(2);
    end else if (state == MUL_RUN) begin
      acc <= (acc << 1) + (mplier[`XLEN-1] ? {{`XLEN{1'b0}}, mcand} : '0);
      mplier <= mplier << 1;
      cnt <= cnt + CW'(1);
    end
  end

  assign m.ready = (state == MUL_DONE);
  assign m.result = (op_q == MOP_MUL) ? acc[`XLEN-1:0] : acc[2*`XLEN-1:`XLEN];

endmodule

// File: include/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// data path width and register index width.
`define XLEN 32
`define REG_AW 5

// one step per multiplier bit plus the sign correction.
`define MUL_STEPS 33

`endif

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module exec_tb \
  -f files.f -o exec_sim \
  && ./obj_dir/exec_sim | tee /dev/stderr | grep -qF "Simulation passed" \
  || exit 1

// File: tb/exec_asserts.sv
module exec_asserts import exec_pkg::*; (
  input logic clk,
  input logic rst,
  input logic wb_wren,
  input logic exc_valid,
  input reg_addr_t wb_waddr,
  input logic mul_enable
);
  timeunit 1ns;
  timeprecision 1ps;

  wb_exc_exclusive: assert property (@(posedge clk) disable iff (!rst)
    !(wb_wren && exc_valid))
    else $error("wb_wren and exc_valid high in the same cycle");

  no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    wb_wren |-> wb_waddr != '0)
    else $error("wb_wren raised for register 0");

  // the multiplier start is a single-cycle pulse.
  enable_pulse: assert property (@(posedge clk) disable iff (!rst)
    mul_enable |=> !mul_enable)
    else $error("multiplier enable held for more than one cycle");

endmodule

bind execute_stage exec_asserts asserts_inst (
  .clk (clk),
  .rst (rst),
  .wb_wren (wb_wren),
  .exc_valid (exc_valid),
  .wb_waddr (wb_waddr),
  .mul_enable (mul_start)
);

// File: tb/exec_tb.sv
`include "exec_config.svh"

module exec_tb import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DONE_LIMIT = 100;
  localparam int QUIET_LIMIT = 4;

  logic clk;
  logic rst;
  logic in_valid;
  word_t in_instr;
  word_t in_pc;
  word_t in_rdata1;
  word_t in_rdata2;
  logic clear;
  logic stall;
  logic wb_wren;
  reg_addr_t wb_waddr;
  word_t wb_wdata;
  logic exc_valid;
  ecause_t exc_cause;

  word_t rng = 32'd85314;
  int n_checks = 0;
  int n_errors = 0;

  // outcome of the last issued instruction.
  int lat;
  logic stall_after;
  logic got_wb;
  logic got_exc;

  exec_top exec_top_inst (
    .clk (clk),
    .rst (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_pc (in_pc),
    .in_rdata1 (in_rdata1),
    .in_rdata2 (in_rdata2),
    .clear (clear),
    .stall (stall),
    .wb_wren (wb_wren),
    .wb_waddr (wb_waddr),
    .wb_wdata (wb_wdata),
    .exc_valid (exc_valid),
    .exc_cause (exc_cause)
  );

  always #50 clk = ~clk;

  function automatic word_t rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t rand_pc();
    word_t r;
    r = rand32();
    return {r[31:2], 2'b00};
  endfunction

  // reference behavior of the RV32I register and immediate operations.
  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // op follows funct3 of the M extension: MUL, MULH, MULHSU, MULHU.
  function automatic word_t mul_model(input logic [1:0] op, input word_t a, input word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (op == 2'd1 || op == 2'd2) ? {{32{a[31]}}, a} : {32'd0, a};
    eb = (op == 2'd1) ? {{32{b[31]}}, b} : {32'd0, b};
    p = ea * eb;
    return (op == 2'd0) ? p[31:0] : p[63:32];
  endfunction

  function automatic word_t csr_instr(input logic [11:0] csr, input reg_addr_t rs1,
                                      input logic [2:0] f3, input reg_addr_t rd);
    return {csr, rs1, f3, rd, 7'h73};
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    n_errors++;
  endtask

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    n_errors++;
  endtask

  // drives one instruction and waits for its writeback or exception.
  task automatic issue(input word_t instr, input word_t pc, input word_t a, input word_t b,
                       input logic expect_done);
    int wait_cnt;
    int limit;
    wait_cnt = 0;
    limit = expect_done ? DONE_LIMIT : QUIET_LIMIT;
    while (stall && wait_cnt < DONE_LIMIT) begin
      @(posedge clk);
      #5;
      wait_cnt++;
    end
    if (stall) begin
      report_error("stage still stalled before a new instruction");
    end
    in_valid = 1'b1;
    in_instr = instr;
    in_pc = pc;
    in_rdata1 = a;
    in_rdata2 = b;
    @(posedge clk);
    #5;
    in_valid = 1'b0;
    lat = 1;
    stall_after = stall;
    while (!wb_wren && !exc_valid && lat < limit) begin
      @(posedge clk);
      #5;
      lat++;
    end
    got_wb = wb_wren;
    got_exc = exc_valid;
    if (expect_done && !got_wb && !got_exc) begin
      report_error("timed out waiting for writeback or exception");
    end
  endtask

  task automatic check_wb(input string name, input reg_addr_t rd, input word_t exp,
                          input int exp_lat);
    n_checks++;
    if (!got_wb) begin
      report_error({name, ": no writeback"});
    end else begin
      if (wb_waddr !== rd) begin
        report_mismatch({name, " waddr"}, 32'(rd), 32'(wb_waddr));
      end
      if (wb_wdata !== exp) begin
        report_mismatch(name, exp, wb_wdata);
      end
      if (lat != exp_lat) begin
        report_mismatch({name, " latency"}, 32'(exp_lat), 32'(lat));
      end
    end
    if (got_exc) begin
      report_error({name, ": unexpected exception"});
    end
  endtask

  task automatic test_alu();
    word_t r;
    word_t a;
    word_t b;
    word_t opb;
    word_t instr;
    logic [11:0] imm12;
    logic [2:0] f3;
    logic alt;
    logic use_imm;
    reg_addr_t rd;
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      a = rand32();
      b = rand32();
      rd = r[4:0];
      if (rd == 5'd0) begin
        rd = 5'd1;
      end
      f3 = r[7:5];
      use_imm = r[8];
      // only SUB, SRA and SRAI have the alternate encoding.
      alt = r[9] && (f3 == 3'd5 || (f3 == 3'd0 && !use_imm));
      if (use_imm) begin
        imm12 = r[31:20];
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm12 = {1'b0, alt, 5'b0, r[24:20]};
        end
        instr = {imm12, 5'd1, f3, rd, 7'h13};
        opb = {{20{imm12[11]}}, imm12};
      end else begin
        instr = {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, rd, 7'h33};
        opb = b;
      end
      issue(instr, rand_pc(), a, b, 1'b1);
      check_wb("test_alu", rd, alu_model(f3, alt, a, opb), 1);
    end
  endtask

  task automatic test_upper_jump();
    word_t r;
    word_t pc;
    word_t instr;
    word_t exp;
    reg_addr_t rd;
    for (int k = 0; k < 4; k++) begin
      r = rand32();
      pc = rand_pc();
      rd = 5'(k + 3);
      case (k)
        0: begin
          instr = {r[31:12], rd, 7'h37};
          exp = {r[31:12], 12'd0};
        end
        1: begin
          instr = {r[31:12], rd, 7'h17};
          exp = pc + {r[31:12], 12'd0};
        end
        2: begin
          instr = {1'b0, 10'd4, 1'b0, 8'd0, rd, 7'h6f};
          exp = pc + 32'd4;
        end
        default: begin
          instr = {12'h010, 5'd3, 3'd0, rd, 7'h67};
          exp = pc + 32'd4;
        end
      endcase
      issue(instr, pc, rand32(), rand32(), 1'b1);
      check_wb("test_upper_jump", rd, exp, 1);
    end
  endtask

  task automatic test_mul();
    word_t a;
    word_t b;
    logic [1:0] op;
    reg_addr_t rd;
    for (int i = 0; i < 12; i++) begin
      a = rand32();
      b = rand32();
      op = 2'(i);
      rd = 5'(i + 1);
      issue({7'b0000001, 5'd2, 5'd1, 1'b0, op, rd, 7'h33}, rand_pc(), a, b, 1'b1);
      if (!stall_after) begin
        report_error("test_mul: stall low after a multiply was accepted");
      end
      check_wb("test_mul", rd, mul_model(op, a, b), `MUL_STEPS + 1);
    end
  endtask

  task automatic test_csr();
    word_t scratch;
    word_t v;
    scratch = 32'd0;
    v = rand32();
    issue(csr_instr(12'h340, 5'd6, 3'd1, 5'd5), rand_pc(), v, 32'd0, 1'b1);
    check_wb("test_csr rw", 5'd5, scratch, 1);
    scratch = v;
    // rs1 is x0, so the set must not write even with nonzero rdata1.
    issue(csr_instr(12'h340, 5'd0, 3'd2, 5'd7), rand_pc(), 32'hffff_ffff, 32'd0, 1'b1);
    check_wb("test_csr read", 5'd7, scratch, 1);
    v = rand32();
    issue(csr_instr(12'h340, 5'd9, 3'd3, 5'd8), rand_pc(), v, 32'd0, 1'b1);
    check_wb("test_csr rc", 5'd8, scratch, 1);
    scratch = scratch & ~v;
    v = rand32();
    issue(csr_instr(12'h340, 5'd11, 3'd2, 5'd10), rand_pc(), v, 32'd0, 1'b1);
    check_wb("test_csr rs", 5'd10, scratch, 1);
    scratch = scratch | v;
    issue(csr_instr(12'h340, 5'd0, 3'd2, 5'd12), rand_pc(), 32'd0, 32'd0, 1'b1);
    check_wb("test_csr final", 5'd12, scratch, 1);
  endtask

  task automatic test_exceptions();
    word_t instr;
    word_t pc;
    logic [3:0] cause;
    for (int k = 0; k < 3; k++) begin
      case (k)
        0: begin
          instr = 32'hffff_ffff;
          cause = 4'd2;
        end
        1: begin
          instr = 32'h0010_0073;
          cause = 4'd3;
        end
        default: begin
          instr = 32'h0000_0073;
          cause = 4'd11;
        end
      endcase
      pc = rand_pc();
      issue(instr, pc, rand32(), rand32(), 1'b1);
      n_checks++;
      if (!got_exc) begin
        report_error("test_exceptions: no exception raised");
      end else if (exc_cause !== cause) begin
        report_mismatch("test_exceptions cause", 32'(cause), 32'(exc_cause));
      end
      if (got_wb) begin
        report_error("test_exceptions: writeback together with an exception");
      end
      issue(csr_instr(12'h342, 5'd0, 3'd2, 5'd1), rand_pc(), 32'd0, 32'd0, 1'b1);
      check_wb("test_exceptions mcause", 5'd1, 32'(cause), 1);
      issue(csr_instr(12'h341, 5'd0, 3'd2, 5'd2), rand_pc(), 32'd0, 32'd0, 1'b1);
      check_wb("test_exceptions mepc", 5'd2, pc, 1);
      issue(csr_instr(12'h343, 5'd0, 3'd2, 5'd3), rand_pc(), 32'd0, 32'd0, 1'b1);
      check_wb("test_exceptions mtval", 5'd3, instr, 1);
    end
  endtask

  task automatic test_kill();
    word_t a;
    word_t b;
    n_checks++;
    issue({12'h005, 5'd1, 3'd0, 5'd0, 7'h13}, rand_pc(), rand32(), rand32(), 1'b0);
    if (got_wb || got_exc) begin
      report_error("test_kill: write to x0 raised wb_wren or an exception");
    end
    n_checks++;
    in_valid = 1'b1;
    in_instr = {7'b0000001, 5'd2, 5'd1, 3'd0, 5'd4, 7'h33};
    in_rdata1 = rand32();
    in_rdata2 = rand32();
    @(posedge clk);
    #5;
    in_valid = 1'b0;
    if (!stall) begin
      report_error("test_kill: stall low after a multiply was accepted");
    end
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #5;
    end
    clear = 1'b1;
    @(posedge clk);
    #5;
    clear = 1'b0;
    if (stall) begin
      report_error("test_kill: stall still high on the edge after clear");
    end
    // the killed multiply finishes inside this window and must stay silent.
    for (int i = 0; i < `MUL_STEPS + 4; i++) begin
      if (wb_wren || exc_valid) begin
        report_error("test_kill: writeback or exception after clear");
      end
      @(posedge clk);
      #5;
    end
    a = rand32();
    b = rand32();
    issue({7'b0000001, 5'd2, 5'd1, 3'd3, 5'd6, 7'h33}, rand_pc(), a, b, 1'b1);
    check_wb("test_kill restart", 5'd6, mul_model(2'd3, a, b), `MUL_STEPS + 1);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    in_valid = 1'b0;
    in_instr = 32'd0;
    in_pc = 32'd0;
    in_rdata1 = 32'd0;
    in_rdata2 = 32'd0;
    clear = 1'b0;
    repeat (5) @(posedge clk);
    #5;
    rst = 1'b1;
    if (stall || wb_wren || exc_valid) begin
      report_error("outputs not idle after reset");
    end
    test_alu();
    test_upper_jump();
    test_mul();
    test_csr();
    test_exceptions();
    test_kill();
    $display("instructions checked: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
